//--- tb.f
am_pkg.sv
am_match.sv
am_lock_fsm.sv
am_lock_top.sv
+incdir+.
tb_am_lock.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_am_lock
FILELIST  ?= tb.f
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- tb_am_model.svh
`ifndef TB_AM_MODEL_SVH
`define TB_AM_MODEL_SVH

logic [31:0]         lfsr_q;
am_pkg::lock_state_e m_state;
int                  m_period;
int                  m_lane;
int                  m_val;
int                  m_inv;
int                  m_err;
logic                exp_lock;
logic                exp_resync;
logic                exp_sol;

// taps 32 22 2 1
function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
endfunction

function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
                r = {r[62:0], lfsr_bit()};
        return r;
endfunction

function automatic logic [65:0] make_payload();
        return {2'b01, rand_bits(64)};
endfunction

function automatic logic [65:0] make_marker(input int lane);
        am_pkg::am_fields_t f;
        f.sync_header     = 2'b10;
        {f.m0, f.m1, f.m2} = am_pkg::am_table[lane];
        f.bip3            = 8'(rand_bits(8));
        f.m4              = ~f.m0;
        f.m5              = ~f.m1;
        f.m6              = ~f.m2;
        f.bip7            = 8'(rand_bits(8));
        return f;
endfunction

// mode 0 wrong byte, 1 broken inverse, 2 data sync header
function automatic logic [65:0] corrupt_marker(input logic [65:0] blk, input int mode);
        am_pkg::am_fields_t f;
        f = blk;
        case (mode)
        0:
        begin
                f.m1 = f.m1 ^ 8'h10;
                f.m5 = ~f.m1;
        end
        1:       f.m6 = f.m6 ^ 8'h01;
        default: f.sync_header = 2'b01;
        endcase
        return f;
endfunction

task automatic model_step(input logic v, input logic [65:0] d, input logic blk);
        am_pkg::am_fields_t f;
        logic               hit;
        int                 lane;
        logic               at;
        f    = d;
        hit  = 1'b0;
        lane = 0;
        exp_resync = 1'b0;
        exp_sol    = 1'b0;
        for (int k = 0; k < am_pkg::N_LANES; k++)
        begin
                if (f.sync_header == 2'b10 && {f.m0, f.m1, f.m2} == am_pkg::am_table[k] &&
                    {f.m4, f.m5, f.m6} == ~am_pkg::am_table[k])
                begin
                        hit  = 1'b1;
                        lane = k;
                end
        end
        if (!blk)
        begin
                m_state = am_pkg::SEARCH;
        end
        else if (v)
        begin
                at       = (m_period == N_BLOCKS - 1);
                m_period = at ? 0 : m_period + 1;
                case (m_state)
                am_pkg::SEARCH:
                begin
                        if (hit)
                        begin
                                m_state  = am_pkg::CONFIRM;
                                m_lane   = lane;
                                m_val    = 1;
                                m_period = 0;
                        end
                end
                am_pkg::CONFIRM:
                begin
                        if (at && hit && lane == m_lane)
                        begin
                                m_val++;
                                if (m_val >= VAL_THR)
                                begin
                                        m_state = am_pkg::LOCKED;
                                        m_inv   = 0;
                                end
                        end
                        else if (at)
                                m_state = am_pkg::SEARCH;
                end
                default:
                begin
                        if (at && hit && lane == m_lane)
                        begin
                                m_inv   = 0;
                                exp_sol = 1'b1;
                        end
                        else if (at)
                        begin
                                m_inv++;
                                if (m_err < 65535)
                                        m_err++;
                                if (m_inv >= INV_THR)
                                begin
                                        m_state    = am_pkg::SEARCH;
                                        exp_resync = 1'b1;
                                end
                        end
                end
                endcase
        end
        exp_lock = (m_state == am_pkg::LOCKED);
endtask

`endif

//--- tb_am_lock.sv
`timescale 1ns/1ns

module tb_am_lock;

        localparam int N_BLOCKS = 10;
        localparam int VAL_THR  = 5;
        localparam int INV_THR  = 3;

        typedef struct packed {
                logic        v;
                logic [65:0] d;
                logic        blk;
        } stim_t;

        logic        tb_clock;
        logic        i_rst_n;
        logic        i_valid;
        logic [65:0] i_data;
        logic        i_block_lock;
        logic [4:0]  i_valid_am_thr;
        logic [3:0]  i_invalid_am_thr;
        logic        o_valid;
        logic [65:0] o_data;
        logic [4:0]  o_lane_id;
        logic        o_lock;
        logic        o_resync;
        logic        o_start_of_lane;
        logic [15:0] o_error_counter;

        stim_t       stim_q[$];
        logic        blk_lvl;
        int          n_errors;
        int          n_resync;
        int          lane;
        int          lane2;

        `include "tb_am_model.svh"

        am_lock_top
        #(
                .N_BLOCKS               (N_BLOCKS),
                .MAX_INV_AM             (8),
                .MAX_VAL_AM             (20),
                .NB_ERROR_COUNTER       (16)
        )
        dut0
        (
                .i_clock                (tb_clock),
                .i_rst_n                (i_rst_n),
                .i_valid                (i_valid),
                .i_data                 (i_data),
                .i_block_lock           (i_block_lock),
                .i_valid_am_thr         (i_valid_am_thr),
                .i_invalid_am_thr       (i_invalid_am_thr),
                .o_valid                (o_valid),
                .o_data                 (o_data),
                .o_lane_id              (o_lane_id),
                .o_lock                 (o_lock),
                .o_resync               (o_resync),
                .o_start_of_lane        (o_start_of_lane),
                .o_error_counter        (o_error_counter)
        );

        initial
        begin
                tb_clock = 1'b0;
                forever #10 tb_clock = ~tb_clock;
        end

        task automatic report_value(input string name, input logic [65:0] exp,
                                    input logic [65:0] got);
                n_errors++;
                $display("[FAIL] %s expected %h got %h", name, exp, got);
                $display("Errors found");
                $fatal(1, "value mismatch");
        endtask

        task automatic report_text(input string what);
                n_errors++;
                $display("%s", what);
                $display("Errors found");
                $fatal(1, "check failed");
        endtask

        // block from two edges ago with the block lock the FSM saw one edge later
        task automatic check_outputs();
                stim_t e;
                e = stim_q.pop_front();
                model_step(e.v, e.d, stim_q[0].blk);
                assert (o_valid === e.v) else report_value("o_valid", e.v, o_valid);
                if (e.v)
                begin
                        assert (o_data === e.d) else report_value("o_data", e.d, o_data);
                end
                assert (o_lock === exp_lock) else report_value("o_lock", exp_lock, o_lock);
                assert (o_resync === exp_resync)
                else report_value("o_resync", exp_resync, o_resync);
                assert (o_start_of_lane === exp_sol)
                else report_value("o_start_of_lane", exp_sol, o_start_of_lane);
                assert (o_error_counter === 16'(m_err))
                else report_value("o_error_counter", m_err, o_error_counter);
                if (m_state != am_pkg::SEARCH)
                begin
                        assert (o_lane_id === 5'(m_lane))
                        else report_value("o_lane_id", m_lane, o_lane_id);
                end
                if (o_resync)
                        n_resync++;
        endtask

        task automatic tick(input logic v, input logic [65:0] d);
                @(negedge tb_clock);
                check_outputs();
                i_valid      = v;
                i_data       = d;
                i_block_lock = blk_lvl;
                stim_q.push_back('{v, d, blk_lvl});
        endtask

        // about one cycle in four left idle
        task automatic send_valid(input logic [65:0] d);
                int n;
                n = 0;
                while (rand_bits(2) == 2'b00 && n < 8)
                begin
                        tick(1'b0, make_payload());
                        n++;
                end
                tick(1'b1, d);
        endtask

        task automatic run_stream(input int n_markers, input int ln, input int n_bad);
                logic [65:0] blk;
                for (int i = 0; i < n_markers; i++)
                begin
                        blk = make_marker(ln);
                        if (i < n_bad)
                                blk = corrupt_marker(blk, i % 3);
                        send_valid(blk);
                        for (int j = 0; j < N_BLOCKS - 1; j++)
                                send_valid(make_payload());
                end
        endtask

        task automatic wait_lock(input logic exp, input int limit);
                int n;
                n = 0;
                while (o_lock !== exp && n < limit)
                begin
                        tick(1'b0, make_payload());
                        n++;
                end
                if (o_lock !== exp)
                        report_text($sformatf("timeout waiting for o_lock to become %0d", exp));
        endtask

        function automatic int other_lane(input int ln);
                int r;
                r = (ln + 1 + int'(rand_bits(4))) % am_pkg::N_LANES;
                return r;
        endfunction

        initial
        begin
                lfsr_q           = 32'h9fc60d55;
                n_errors         = 0;
                n_resync         = 0;
                m_state          = am_pkg::SEARCH;
                m_period         = 0;
                m_lane           = 0;
                m_val            = 0;
                m_inv            = 0;
                m_err            = 0;
                blk_lvl          = 1'b1;
                i_rst_n          = 1'b0;
                i_valid          = 1'b0;
                i_data           = '0;
                i_block_lock     = 1'b1;
                i_valid_am_thr   = 5'(VAL_THR);
                i_invalid_am_thr = 4'(INV_THR);
                repeat (2) @(posedge tb_clock);
                @(negedge tb_clock);
                i_rst_n = 1'b1;
                stim_q.push_back('{1'b0, 66'h0, 1'b1});
                stim_q.push_back('{1'b0, 66'h0, 1'b1});

                lane = int'(rand_bits(5)) % am_pkg::N_LANES;          // acquisition
                run_stream(VAL_THR, lane, 0);
                wait_lock(1'b1, 30);
                assert (o_lane_id === 5'(lane)) else report_value("o_lane_id", lane, o_lane_id);
                run_stream(3, lane, 0);

                run_stream(3, lane, 2);                                  // two bad then one good
                run_stream(2, lane, 1);
                wait_lock(1'b1, 4);
                assert (o_error_counter === 16'd3)
                else report_value("o_error_counter", 3, o_error_counter);

                run_stream(3, lane, 3);                                  // loss of lock
                wait_lock(1'b0, 30);
                assert (n_resync == 1)
                else report_text("o_resync did not pulse once on loss of lock");
                lane2 = other_lane(lane);
                run_stream(VAL_THR + 1, lane2, 0);
                wait_lock(1'b1, 30);

                blk_lvl = 1'b0;                                         // block lock dropped
                wait_lock(1'b0, 6);
                repeat (3) tick(1'b0, make_payload());
                blk_lvl = 1'b1;
                run_stream(2, lane2, 0);
                run_stream(1, other_lane(lane2), 0);                    // foreign lane in CONFIRM
                run_stream(VAL_THR - 1, lane2, 0);
                repeat (3) tick(1'b0, make_payload());
                assert (o_lock === 1'b0) else report_value("o_lock", 0, o_lock);
                run_stream(2, lane2, 0);
                wait_lock(1'b1, 30);
                run_stream(2, lane2, 0);
                repeat (4) tick(1'b0, make_payload());

                if (n_errors == 0)
                        $display("No errors");
                else
                        $display("Errors found");
                $finish;
        end

endmodule

//--- am_lock_top.sv
`timescale 1ns/1ns

module am_lock_top
#(
        parameter int N_BLOCKS         = 10,
        parameter int MAX_INV_AM       = 8,
        parameter int MAX_VAL_AM       = 20,
        parameter int NB_ERROR_COUNTER = 16
)
(
        input  logic                                  i_clock,
        input  logic                                  i_rst_n,
        input  logic                                  i_valid,
        input  logic [am_pkg::NB_CODED_BLOCK-1:0]     i_data,
        input  logic                                  i_block_lock,
        input  logic [$clog2(MAX_VAL_AM+1)-1:0]       i_valid_am_thr,
        input  logic [$clog2(MAX_INV_AM+1)-1:0]       i_invalid_am_thr,

        output logic                                  o_valid,
        output logic [am_pkg::NB_CODED_BLOCK-1:0]     o_data,
        output logic [am_pkg::NB_LANE_ID-1:0]         o_lane_id,
        output logic                                  o_lock,
        output logic                                  o_resync,
        output logic                                  o_start_of_lane,
        output logic [NB_ERROR_COUNTER-1:0]           o_error_counter
);

        logic                        match_valid;
        am_pkg::coded_block_u        match_data;
        am_pkg::am_hit_t             match_hit;
        am_pkg::coded_block_u        fsm_data;

        // first stage, marker recognition
        am_match u_match
        (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_valid        (i_valid),
                .i_data         (i_data),
                .o_valid        (match_valid),
                .o_data         (match_data),
                .o_hit          (match_hit)
        );

        // second stage, lock tracking
        am_lock_fsm
        #(
                .N_BLOCKS               (N_BLOCKS),
                .MAX_INV_AM             (MAX_INV_AM),
                .MAX_VAL_AM             (MAX_VAL_AM),
                .NB_ERROR_COUNTER       (NB_ERROR_COUNTER)
        )
        u_lock_fsm
        (
                .i_clock                (i_clock),
                .i_rst_n                (i_rst_n),
                .i_valid                (match_valid),
                .i_data                 (match_data),
                .i_hit                  (match_hit),
                .i_block_lock           (i_block_lock),
                .i_valid_am_thr         (i_valid_am_thr),
                .i_invalid_am_thr       (i_invalid_am_thr),
                .o_valid                (o_valid),
                .o_data                 (fsm_data),
                .o_lane_id              (o_lane_id),
                .o_lock                 (o_lock),
                .o_resync               (o_resync),
                .o_start_of_lane        (o_start_of_lane),
                .o_error_counter        (o_error_counter)
        );

        assign o_data = fsm_data.raw;                           // back to a plain word

endmodule

//--- am_lock_fsm.sv
`timescale 1ns/1ns

module am_lock_fsm
#(
        parameter int N_BLOCKS         = 10,
        parameter int MAX_INV_AM       = 8,
        parameter int MAX_VAL_AM       = 20,
        parameter int NB_ERROR_COUNTER = 16
)
(
        input  logic                              i_clock,
        input  logic                              i_rst_n,
        input  logic                              i_valid,
        input  am_pkg::coded_block_u              i_data,
        input  am_pkg::am_hit_t                   i_hit,
        input  logic                              i_block_lock,
        input  logic [$clog2(MAX_VAL_AM+1)-1:0]   i_valid_am_thr,
        input  logic [$clog2(MAX_INV_AM+1)-1:0]   i_invalid_am_thr,

        output logic                              o_valid,
        output am_pkg::coded_block_u              o_data,
        output logic [am_pkg::NB_LANE_ID-1:0]     o_lane_id,
        output logic                              o_lock,
        output logic                              o_resync,
        output logic                              o_start_of_lane,
        output logic [NB_ERROR_COUNTER-1:0]       o_error_counter
);

        localparam int NB_VAL_AM = $clog2(MAX_VAL_AM+1);
        localparam int NB_INV_AM = $clog2(MAX_INV_AM+1);
        localparam int NB_PERIOD = $clog2(N_BLOCKS);
        localparam logic [NB_PERIOD-1:0] LAST_POS = NB_PERIOD'(N_BLOCKS-1);

        am_pkg::lock_state_e              state;
        am_pkg::lock_state_e              state_next;
        logic [NB_PERIOD-1:0]             period_cnt;
        logic [NB_PERIOD-1:0]             period_next;
        logic [am_pkg::NB_LANE_ID-1:0]    lane_r;
        logic [am_pkg::NB_LANE_ID-1:0]    lane_next;
        logic [NB_VAL_AM-1:0]             val_cnt;
        logic [NB_VAL_AM-1:0]             val_next;
        logic [NB_VAL_AM-1:0]             val_inc;
        logic [NB_INV_AM-1:0]             inv_cnt;
        logic [NB_INV_AM-1:0]             inv_next;
        logic [NB_INV_AM-1:0]             inv_inc;
        logic [NB_ERROR_COUNTER-1:0]      err_cnt;
        logic [NB_ERROR_COUNTER-1:0]      err_next;
        logic                             resync_next;
        logic                             sol_next;
        logic                             at_marker;
        logic                             good_am;

        assign at_marker = (period_cnt == LAST_POS);          // expected marker slot
        assign good_am   = i_hit.hit && (i_hit.lane_id == lane_r);
        assign val_inc   = val_cnt + 1'b1;
        assign inv_inc   = inv_cnt + 1'b1;

        always_comb
        begin
                state_next  = state;
                period_next = period_cnt;
                lane_next   = lane_r;
                val_next    = val_cnt;
                inv_next    = inv_cnt;
                err_next    = err_cnt;
                resync_next = 1'b0;
                sol_next    = 1'b0;

                if (!i_block_lock)
                begin
                        state_next = am_pkg::SEARCH;                    // no block lock yet
                end
                else if (i_valid)
                begin
                        period_next = at_marker ? '0 : period_cnt + 1'b1;
                        case (state)
                        am_pkg::SEARCH:
                        begin
                                if (i_hit.hit)
                                begin
                                        state_next  = am_pkg::CONFIRM;
                                        lane_next   = i_hit.lane_id;
                                        val_next    = NB_VAL_AM'(1);
                                        period_next = '0;
                                end
                        end
                        am_pkg::CONFIRM:
                        begin
                                if (at_marker)
                                begin
                                        if (good_am)
                                        begin
                                                val_next = val_inc;
                                                if (val_inc >= i_valid_am_thr)
                                                begin
                                                        state_next = am_pkg::LOCKED;
                                                        inv_next   = '0;
                                                end
                                        end
                                        else
                                        begin
                                                state_next = am_pkg::SEARCH;
                                        end
                                end
                        end
                        am_pkg::LOCKED:
                        begin
                                if (at_marker && good_am)
                                begin
                                        inv_next = '0;
                                        sol_next = 1'b1;
                                end
                                else if (at_marker)
                                begin
                                        inv_next = inv_inc;
                                        if (err_cnt != '1)
                                                err_next = err_cnt + 1'b1;  // saturating
                                        if (inv_inc >= i_invalid_am_thr)
                                        begin
                                                state_next  = am_pkg::SEARCH;
                                                resync_next = 1'b1;
                                        end
                                end
                        end
                        default:
                        begin
                                state_next = am_pkg::SEARCH;
                        end
                        endcase
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        state           <= am_pkg::SEARCH;
                        period_cnt      <= '0;
                        lane_r          <= '0;
                        val_cnt         <= '0;
                        inv_cnt         <= '0;
                        err_cnt         <= '0;
                        o_valid         <= 1'b0;
                        o_resync        <= 1'b0;
                        o_start_of_lane <= 1'b0;
                end
                else
                begin
                        state           <= state_next;
                        period_cnt      <= period_next;
                        lane_r          <= lane_next;
                        val_cnt         <= val_next;
                        inv_cnt         <= inv_next;
                        err_cnt         <= err_next;
                        o_valid         <= i_valid;
                        o_resync        <= resync_next;
                        o_start_of_lane <= sol_next;
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                        o_data <= i_data;
        end

        assign o_lock          = (state == am_pkg::LOCKED);
        assign o_lane_id       = lane_r;
        assign o_error_counter = err_cnt;

        a_resync_from_locked : assert property (
                @(posedge i_clock) disable iff (!i_rst_n)
                o_resync |-> ($past(state) == am_pkg::LOCKED)
        );

        a_sol_when_locked : assert property (
                @(posedge i_clock) disable iff (!i_rst_n)
                o_start_of_lane |-> (o_lock && o_valid)
        );

endmodule

//--- am_match.sv
`timescale 1ns/1ns

module am_match
(
        input  logic                 i_clock,
        input  logic                 i_rst_n,
        input  logic                 i_valid,
        input  am_pkg::coded_block_u i_data,

        output logic                 o_valid,
        output am_pkg::coded_block_u o_data,
        output am_pkg::am_hit_t      o_hit
);

        am_pkg::am_fields_t          fields;
        logic                        ctrl_ok;
        logic                        inv_ok;
        logic [am_pkg::N_LANES-1:0]  lane_match;
        am_pkg::am_hit_t             hit_next;

        assign fields  = i_data.am;
        assign ctrl_ok = (fields.sync_header == 2'b10);        // control block

        // second half of a marker repeats the first half inverted
        assign inv_ok = (fields.m4 == ~fields.m0) &&
                        (fields.m5 == ~fields.m1) &&
                        (fields.m6 == ~fields.m2);

        // all table entries compared at once
        always_comb
        begin
                for (int k = 0; k < am_pkg::N_LANES; k++)
                begin
                        lane_match[k] = ctrl_ok && inv_ok &&
                                ({fields.m0, fields.m1, fields.m2} == am_pkg::am_table[k]);
                end
        end

        // entries are distinct, so at most one bit is set
        always_comb
        begin
                hit_next = '0;
                for (int k = 0; k < am_pkg::N_LANES; k++)
                begin
                        if (lane_match[k])
                        begin
                                hit_next.hit     = 1'b1;
                                hit_next.lane_id = k[am_pkg::NB_LANE_ID-1:0];
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        o_valid   <= 1'b0;
                        o_hit.hit <= 1'b0;
                end
                else
                begin
                        o_valid   <= i_valid;
                        o_hit.hit <= i_valid & hit_next.hit;    // only qualified blocks
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                begin
                        o_data        <= i_data;
                        o_hit.lane_id <= hit_next.lane_id;
                end
        end

        a_lane_in_range : assert property (
                @(posedge i_clock) disable iff (!i_rst_n)
                o_hit.hit |-> (o_hit.lane_id < am_pkg::N_LANES)
        );

endmodule

//--- am_pkg.sv
package am_pkg;

        localparam int NB_CODED_BLOCK = 66;
        localparam int N_LANES        = 20;
        localparam int NB_LANE_ID     = $clog2(N_LANES);

        // M0 M1 M2 per lane, lane 0 first
        localparam logic [23:0] am_table [N_LANES] = '{
                24'hC1_68_21,
                24'h9D_71_8E,
                24'h59_4B_E8,
                24'h4D_95_7B,
                24'hF5_07_09,
                24'hDD_14_C2,
                24'h9A_4A_26,
                24'h7B_45_66,
                24'hA0_24_76,
                24'h68_C9_FB,
                24'hFD_6C_99,
                24'hB9_91_55,
                24'h5C_B9_B2,
                24'h1A_F8_BD,
                24'h83_C7_CA,
                24'h35_36_CD,
                24'hC4_31_4C,
                24'hAD_D6_B7,
                24'h5F_66_2A,
                24'hC0_F0_E5
        };

        // marker view of a block, sync header in the top two bits
        typedef struct packed {
                logic [1:0] sync_header;
                logic [7:0] m0;
                logic [7:0] m1;
                logic [7:0] m2;
                logic [7:0] bip3;               // ignored
                logic [7:0] m4;
                logic [7:0] m5;
                logic [7:0] m6;
                logic [7:0] bip7;               // ignored
        } am_fields_t;

        // payload word or marker fields
        typedef union packed {
                logic [NB_CODED_BLOCK-1:0] raw;
                am_fields_t                am;
        } coded_block_u;

        typedef struct packed {
                logic                  hit;
                logic [NB_LANE_ID-1:0] lane_id;
        } am_hit_t;

        typedef enum logic [1:0] {
                SEARCH  = 2'd0,
                CONFIRM = 2'd1,
                LOCKED  = 2'd2
        } lock_state_e;

endpackage
